// ==== hw/cl_decode.sv ====
`timescale 1ns/1ps

module cl_decode (
    input  rv32_pkg::instr_t instruction_i,
    output rv32_pkg::ctrl_t  decode_o
);

    logic [6:0]          op;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    rv32_pkg::reg_addr_t rd;
    rv32_pkg::reg_addr_t rs1;
    logic                is_mem;
    logic                is_load;
    logic                is_amo_w;
    logic                is_lr;

    assign op     = instruction_i[6:0];
    assign rd     = instruction_i[11:7];
    assign funct3 = instruction_i[14:12];
    assign rs1    = instruction_i[19:15];
    assign funct7 = instruction_i[31:25];

    assign is_amo_w = (op == rv32_pkg::OP_AMO) && (funct3 == 3'b010);
    assign is_lr    = (instruction_i ==? rv32_pkg::LR_W_PATTERN);

    // Memory and load class, FLW and FSW included
    always_comb begin
        case (op)
            rv32_pkg::OP_LOAD, rv32_pkg::OP_LOAD_FP: begin
                is_mem  = 1'b1;
                is_load = 1'b1;
            end
            rv32_pkg::OP_STORE, rv32_pkg::OP_STORE_FP: begin
                is_mem  = 1'b1;
                is_load = 1'b0;
            end
            rv32_pkg::OP_AMO: begin
                is_mem  = 1'b1;
                is_load = (funct7 != rv32_pkg::FUNCT7_SWAP_RL);
            end
            default: begin
                is_mem  = 1'b0;
                is_load = 1'b0;
            end
        endcase
    end

    always_comb begin
        decode_o = '0;

        case (op)
            rv32_pkg::OP_LUI, rv32_pkg::OP_AUIPC, rv32_pkg::OP_JAL, rv32_pkg::OP_JALR,
            rv32_pkg::OP_LOAD, rv32_pkg::OP_OP, rv32_pkg::OP_IMM, rv32_pkg::OP_AMO:
                decode_o[rv32_pkg::CTRL_WRITES_RF] = (rd != 5'd0); // x0 is never written
            default: ;
        endcase

        decode_o[rv32_pkg::CTRL_IS_MEM]  = is_mem;
        // funct3 x00 is byte, x01 is half
        decode_o[rv32_pkg::CTRL_IS_BYTE] = is_mem && (funct3[1:0] == 2'b00);
        decode_o[rv32_pkg::CTRL_IS_HEX]  = is_mem && (funct3[1:0] == 2'b01);
        decode_o[rv32_pkg::CTRL_IS_LOAD] = is_load;
        decode_o[rv32_pkg::CTRL_LOAD_UNSIGNED] = is_load && funct3[2];

        case (op)
            rv32_pkg::OP_STORE, rv32_pkg::OP_STORE_FP:
                decode_o[rv32_pkg::CTRL_IS_STORE] = 1'b1;
            rv32_pkg::OP_AMO:
                decode_o[rv32_pkg::CTRL_IS_STORE] = (funct7 == rv32_pkg::FUNCT7_SWAP_RL);
            default: ;
        endcase

        decode_o[rv32_pkg::CTRL_IS_BRANCH] = (op == rv32_pkg::OP_BRANCH);
        decode_o[rv32_pkg::CTRL_IS_JUMP]   = (op == rv32_pkg::OP_JAL) || (op == rv32_pkg::OP_JALR);

        case (op)
            rv32_pkg::OP_JALR, rv32_pkg::OP_BRANCH, rv32_pkg::OP_LOAD, rv32_pkg::OP_STORE,
            rv32_pkg::OP_OP, rv32_pkg::OP_IMM, rv32_pkg::OP_AMO,
            rv32_pkg::OP_LOAD_FP, rv32_pkg::OP_STORE_FP:
                decode_o[rv32_pkg::CTRL_READS_RF1] = 1'b1;
            default: ;
        endcase

        // LR has no rs2, only the swaps read it among the AMOs
        case (op)
            rv32_pkg::OP_BRANCH, rv32_pkg::OP_STORE, rv32_pkg::OP_OP:
                decode_o[rv32_pkg::CTRL_READS_RF2] = 1'b1;
            rv32_pkg::OP_AMO:
                decode_o[rv32_pkg::CTRL_READS_RF2] = (funct7 == rv32_pkg::FUNCT7_SWAP_AQ)
                                                   || (funct7 == rv32_pkg::FUNCT7_SWAP_RL);
            default: ;
        endcase

        decode_o[rv32_pkg::CTRL_IS_AUIPC] = (op == rv32_pkg::OP_AUIPC);
        decode_o[rv32_pkg::CTRL_IS_MD]    = (op == rv32_pkg::OP_OP)
                                          && (funct7 == rv32_pkg::FUNCT7_MULDIV);
        decode_o[rv32_pkg::CTRL_IS_LR]    = is_lr;
        decode_o[rv32_pkg::CTRL_LR_ACQ]   = is_lr && instruction_i[26];

        decode_o[rv32_pkg::CTRL_IS_FENCE] = (op == rv32_pkg::OP_MISC_MEM)
                                          && (funct3 == rv32_pkg::FUNCT3_FENCE)
                                          && (rs1 == 5'd0) && (rd == 5'd0)
                                          && (instruction_i[31:28] == 4'd0);
        decode_o[rv32_pkg::CTRL_IS_FENCE_I] = (op == rv32_pkg::OP_MISC_MEM)
                                            && (funct3 == rv32_pkg::FUNCT3_FENCE_I)
                                            && (rs1 == 5'd0) && (rd == 5'd0)
                                            && (instruction_i[31:20] == 12'd0);

        decode_o[rv32_pkg::CTRL_SWAP_AQ] = is_amo_w && (funct7 == rv32_pkg::FUNCT7_SWAP_AQ);
        decode_o[rv32_pkg::CTRL_SWAP_RL] = is_amo_w && (funct7 == rv32_pkg::FUNCT7_SWAP_RL);
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  rv32_pkg::instr_t    instr_i,
    output logic                ready_o,
    output logic                valid_o,
    output rv32_pkg::ctrl_t     ctrl_o,
    output rv32_pkg::reg_addr_t rd_o,
    output rv32_pkg::reg_addr_t rs1_o,
    output rv32_pkg::reg_addr_t rs2_o,
    output rv32_pkg::word_t     imm_o,
    input  logic                ready_i
);

    rv32_pkg::ctrl_t ctrl_d;
    rv32_pkg::word_t imm_d;
    logic            load;

    cl_decode i_cl_decode (
        .instruction_i (instr_i),
        .decode_o      (ctrl_d)
    );

    // Immediate by instruction format, sign taken from bit 31
    always_comb begin
        case (instr_i[6:0])
            rv32_pkg::OP_LOAD, rv32_pkg::OP_LOAD_FP, rv32_pkg::OP_IMM,
            rv32_pkg::OP_JALR, rv32_pkg::OP_AMO:
                imm_d = {{20{instr_i[31]}}, instr_i[31:20]};
            rv32_pkg::OP_STORE, rv32_pkg::OP_STORE_FP:
                imm_d = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            rv32_pkg::OP_BRANCH:
                imm_d = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            rv32_pkg::OP_LUI, rv32_pkg::OP_AUIPC:
                imm_d = {instr_i[31:12], 12'd0};
            rv32_pkg::OP_JAL:
                imm_d = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            default:
                imm_d = '0;
        endcase
    end

    // Free when empty or when the operand stage takes the current entry
    assign ready_o = !valid_o || ready_i;
    assign load    = valid_i && ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            ctrl_o <= ctrl_d;
            rd_o   <= instr_i[11:7];
            rs1_o  <= instr_i[19:15];
            rs2_o  <= instr_i[24:20];
            imm_o  <= imm_d;
        end
    end

endmodule

// ==== hw/decode_top.sv ====
`timescale 1ns/1ps

module decode_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                in_req_i,
    output logic                in_ack_o,
    input  rv32_pkg::instr_t    in_instr_i,
    output logic                out_req_o,
    input  logic                out_ack_i,
    output rv32_pkg::ctrl_t     out_ctrl_o,
    output rv32_pkg::reg_addr_t out_rd_o,
    output rv32_pkg::word_t     out_imm_o,
    output rv32_pkg::word_t     out_rs1_val_o,
    output rv32_pkg::word_t     out_rs2_val_o,
    input  logic                wb_en_i,
    input  rv32_pkg::reg_addr_t wb_addr_i,
    input  rv32_pkg::word_t     wb_data_i
);

    logic                rx_valid;
    logic                rx_ready;
    rv32_pkg::instr_t    rx_instr;

    logic                dec_valid;
    logic                dec_ready;
    rv32_pkg::ctrl_t     dec_ctrl;
    rv32_pkg::reg_addr_t dec_rd;
    rv32_pkg::reg_addr_t dec_rs1;
    rv32_pkg::reg_addr_t dec_rs2;
    rv32_pkg::word_t     dec_imm;

    logic                op_valid;
    logic                op_ready;
    rv32_pkg::ctrl_t     op_ctrl;
    rv32_pkg::reg_addr_t op_rd;
    rv32_pkg::word_t     op_imm;
    rv32_pkg::word_t     op_rs1_val;
    rv32_pkg::word_t     op_rs2_val;

    instr_rx i_instr_rx (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .in_req_i   (in_req_i),
        .in_instr_i (in_instr_i),
        .in_ack_o   (in_ack_o),
        .valid_o    (rx_valid),
        .instr_o    (rx_instr),
        .ready_i    (rx_ready)
    );

    decode_stage i_decode_stage (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (rx_valid),
        .instr_i (rx_instr),
        .ready_o (rx_ready),
        .valid_o (dec_valid),
        .ctrl_o  (dec_ctrl),
        .rd_o    (dec_rd),
        .rs1_o   (dec_rs1),
        .rs2_o   (dec_rs2),
        .imm_o   (dec_imm),
        .ready_i (dec_ready)
    );

    // Register file lives here, written from outside
    operand_stage i_operand_stage (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (dec_valid),
        .ctrl_i    (dec_ctrl),
        .rd_i      (dec_rd),
        .rs1_i     (dec_rs1),
        .rs2_i     (dec_rs2),
        .imm_i     (dec_imm),
        .ready_o   (dec_ready),
        .wb_en_i   (wb_en_i),
        .wb_addr_i (wb_addr_i),
        .wb_data_i (wb_data_i),
        .valid_o   (op_valid),
        .ctrl_o    (op_ctrl),
        .rd_o      (op_rd),
        .imm_o     (op_imm),
        .rs1_val_o (op_rs1_val),
        .rs2_val_o (op_rs2_val),
        .ready_i   (op_ready)
    );

    result_tx i_result_tx (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .valid_i       (op_valid),
        .ctrl_i        (op_ctrl),
        .rd_i          (op_rd),
        .imm_i         (op_imm),
        .rs1_val_i     (op_rs1_val),
        .rs2_val_i     (op_rs2_val),
        .ready_o       (op_ready),
        .out_req_o     (out_req_o),
        .out_ack_i     (out_ack_i),
        .out_ctrl_o    (out_ctrl_o),
        .out_rd_o      (out_rd_o),
        .out_imm_o     (out_imm_o),
        .out_rs1_val_o (out_rs1_val_o),
        .out_rs2_val_o (out_rs2_val_o)
    );

endmodule

// ==== hw/instr_rx.sv ====
`timescale 1ns/1ps

module instr_rx (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             in_req_i,
    input  rv32_pkg::instr_t in_instr_i,
    output logic             in_ack_o,
    output logic             valid_o,
    output rv32_pkg::instr_t instr_o,
    input  logic             ready_i
);

    // IDLE: empty, ack low; WAIT_LOW: ack high; HOLD: ack low, word still buffered
    typedef enum logic [1:0] {IDLE, HOLD, WAIT_LOW} rx_state_t;

    rx_state_t state;
    logic      taken;

    assign taken    = valid_o && ready_i;
    assign in_ack_o = (state == WAIT_LOW);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state   <= IDLE;
            valid_o <= 1'b0;
        end else begin
            if (taken) begin
                valid_o <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (in_req_i) begin
                        valid_o <= 1'b1;
                        state   <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    // Release ack, but keep the buffer until decode takes it
                    if (!in_req_i) begin
                        state <= (valid_o && !taken) ? HOLD : IDLE;
                    end
                end
                HOLD: begin
                    if (taken) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE && in_req_i) begin
            instr_o <= in_instr_i;
        end
    end

endmodule

// ==== hw/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  rv32_pkg::ctrl_t     ctrl_i,
    input  rv32_pkg::reg_addr_t rd_i,
    input  rv32_pkg::reg_addr_t rs1_i,
    input  rv32_pkg::reg_addr_t rs2_i,
    input  rv32_pkg::word_t     imm_i,
    output logic                ready_o,
    input  logic                wb_en_i,
    input  rv32_pkg::reg_addr_t wb_addr_i,
    input  rv32_pkg::word_t     wb_data_i,
    output logic                valid_o,
    output rv32_pkg::ctrl_t     ctrl_o,
    output rv32_pkg::reg_addr_t rd_o,
    output rv32_pkg::word_t     imm_o,
    output rv32_pkg::word_t     rs1_val_o,
    output rv32_pkg::word_t     rs2_val_o,
    input  logic                ready_i
);

    rv32_pkg::word_t rf [32];
    logic            load;

    // One read port, with the same-edge writeback forwarded
    function automatic rv32_pkg::word_t read_port(input rv32_pkg::reg_addr_t addr,
                                                  input logic en);
        rv32_pkg::word_t val;
        if (!en || addr == 5'd0) begin
            val = '0;
        end else if (wb_en_i && wb_addr_i == addr) begin
            val = wb_data_i;
        end else begin
            val = rf[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk_i) begin
        if (wb_en_i && wb_addr_i != 5'd0) begin
            rf[wb_addr_i] <= wb_data_i;
        end
    end

    assign ready_o = !valid_o || ready_i;
    assign load    = valid_i && ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (ready_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            ctrl_o    <= ctrl_i;
            rd_o      <= rd_i;
            imm_o     <= imm_i;
            rs1_val_o <= read_port(rs1_i, ctrl_i[rv32_pkg::CTRL_READS_RF1]);
            rs2_val_o <= read_port(rs2_i, ctrl_i[rv32_pkg::CTRL_READS_RF2]);
        end
    end

endmodule

// ==== hw/result_tx.sv ====
`timescale 1ns/1ps

module result_tx (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  rv32_pkg::ctrl_t     ctrl_i,
    input  rv32_pkg::reg_addr_t rd_i,
    input  rv32_pkg::word_t     imm_i,
    input  rv32_pkg::word_t     rs1_val_i,
    input  rv32_pkg::word_t     rs2_val_i,
    output logic                ready_o,
    output logic                out_req_o,
    input  logic                out_ack_i,
    output rv32_pkg::ctrl_t     out_ctrl_o,
    output rv32_pkg::reg_addr_t out_rd_o,
    output rv32_pkg::word_t     out_imm_o,
    output rv32_pkg::word_t     out_rs1_val_o,
    output rv32_pkg::word_t     out_rs2_val_o
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} tx_state_t;

    tx_state_t state;

    assign ready_o   = (state == IDLE);
    assign out_req_o = (state == REQ);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:         if (valid_i) state <= REQ;
                REQ:          if (out_ack_i) state <= WAIT_ACK_LOW;
                WAIT_ACK_LOW: if (!out_ack_i) state <= IDLE;
                default:      state <= IDLE;
            endcase
        end
    end

    // Bundle only changes in IDLE, so it is stable for the whole handshake
    always_ff @(posedge clk_i) begin
        if (ready_o && valid_i) begin
            out_ctrl_o    <= ctrl_i;
            out_rd_o      <= rd_i;
            out_imm_o     <= imm_i;
            out_rs1_val_o <= rs1_val_i;
            out_rs2_val_o <= rs2_val_i;
        end
    end

endmodule

// ==== hw/rv32_pkg.sv ====
package rv32_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] instr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [18:0] ctrl_t;

    // Bit positions inside the control-flag vector
    localparam int CTRL_WRITES_RF     = 0;
    localparam int CTRL_IS_MEM        = 1;
    localparam int CTRL_IS_BYTE       = 2;
    localparam int CTRL_IS_HEX        = 3;
    localparam int CTRL_IS_LOAD       = 4;
    localparam int CTRL_LOAD_UNSIGNED = 5;
    localparam int CTRL_IS_STORE      = 6;
    localparam int CTRL_IS_BRANCH     = 7;
    localparam int CTRL_IS_JUMP       = 8;
    localparam int CTRL_READS_RF1     = 9;
    localparam int CTRL_READS_RF2     = 10;
    localparam int CTRL_IS_AUIPC      = 11;
    localparam int CTRL_IS_MD         = 12;
    localparam int CTRL_IS_LR         = 13;
    localparam int CTRL_LR_ACQ        = 14;
    localparam int CTRL_IS_FENCE      = 15;
    localparam int CTRL_IS_FENCE_I    = 16;
    localparam int CTRL_SWAP_AQ       = 17;
    localparam int CTRL_SWAP_RL       = 18;

    // Major opcodes
    localparam logic [6:0] OP_LUI      = 7'b0110111;
    localparam logic [6:0] OP_AUIPC    = 7'b0010111;
    localparam logic [6:0] OP_JAL      = 7'b1101111;
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_BRANCH   = 7'b1100011;
    localparam logic [6:0] OP_LOAD     = 7'b0000011;
    localparam logic [6:0] OP_STORE    = 7'b0100011;
    localparam logic [6:0] OP_IMM      = 7'b0010011;
    localparam logic [6:0] OP_OP       = 7'b0110011;
    localparam logic [6:0] OP_AMO      = 7'b0101111;
    localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OP_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OP_STORE_FP = 7'b0100111;

    // AMOSWAP is funct5 00001 followed by the aq and rl bits
    localparam logic [6:0] FUNCT7_MULDIV  = 7'b0000001;
    localparam logic [6:0] FUNCT7_SWAP_AQ = 7'b0000110;
    localparam logic [6:0] FUNCT7_SWAP_RL = 7'b0000101;

    localparam logic [2:0] FUNCT3_FENCE   = 3'b000;
    localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;

    // LR.W with aq and rl left open
    localparam logic [31:0] LR_W_PATTERN = 32'b00010_??_00000_?????_010_?????_0101111;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the decode front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tb_decode_top -o tb_decode_top

# The log decides the result, a fatal stop leaves no pass line
./obj_dir/tb_decode_top | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// ==== testbench/tb_decode_top.sv ====
`timescale 1ns/1ps

module tb_decode_top;

    localparam int WAIT_CYCLES = 200;

    // Common opcode classes appear twice in the random mix
    localparam logic [6:0] OPCODE_POOL [16] = '{
        rv32_pkg::OP_LUI, rv32_pkg::OP_AUIPC, rv32_pkg::OP_JAL, rv32_pkg::OP_JALR,
        rv32_pkg::OP_BRANCH, rv32_pkg::OP_LOAD, rv32_pkg::OP_STORE, rv32_pkg::OP_IMM,
        rv32_pkg::OP_OP, rv32_pkg::OP_AMO, rv32_pkg::OP_MISC_MEM, rv32_pkg::OP_LOAD_FP,
        rv32_pkg::OP_STORE_FP, rv32_pkg::OP_OP, rv32_pkg::OP_IMM, rv32_pkg::OP_AMO
    };

    typedef struct packed {
        rv32_pkg::ctrl_t     ctrl;
        rv32_pkg::reg_addr_t rd;
        rv32_pkg::word_t     imm;
        rv32_pkg::word_t     rs1_val;
        rv32_pkg::word_t     rs2_val;
    } bundle_t;

    logic                clk_i;
    logic                reset_i;
    logic                in_req_i;
    logic                in_ack_o;
    rv32_pkg::instr_t    in_instr_i;
    logic                out_req_o;
    logic                out_ack_i;
    rv32_pkg::ctrl_t     out_ctrl_o;
    rv32_pkg::reg_addr_t out_rd_o;
    rv32_pkg::word_t     out_imm_o;
    rv32_pkg::word_t     out_rs1_val_o;
    rv32_pkg::word_t     out_rs2_val_o;
    logic                wb_en_i;
    rv32_pkg::reg_addr_t wb_addr_i;
    rv32_pkg::word_t     wb_data_i;

    rv32_pkg::word_t     shadow [32];
    rv32_pkg::instr_t    stim_q [$];
    bundle_t             exp_q [$];
    bundle_t             out_bundle;
    logic                first_req_seen;
    integer              seed;

    decode_top i_dut (.*);

    assign out_bundle = {out_ctrl_o, out_rd_o, out_imm_o, out_rs1_val_o, out_rs2_val_o};

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic give_up(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
            else give_up($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    // Handshake rules on both ports
    assert property (@(posedge clk_i) disable iff (reset_i)
        !first_req_seen |-> !in_ack_o && !out_req_o)
        else give_up("in_ack_o or out_req_o went high before the first request");
    // Ack answers the request seen on the edge before
    assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(in_ack_o) |-> $past(in_req_i))
        else give_up("in_ack_o rose while in_req_i was low");
    assert property (@(posedge clk_i) disable iff (reset_i)
        out_req_o && !out_ack_i |=> out_req_o)
        else give_up("out_req_o dropped before out_ack_i rose");
    assert property (@(posedge clk_i) disable iff (reset_i)
        out_req_o |=> !out_req_o || $stable(out_bundle))
        else give_up("output bundle changed while out_req_o was high");

    function automatic rv32_pkg::ctrl_t model_ctrl(input rv32_pkg::instr_t w);
        rv32_pkg::ctrl_t c;
        logic [6:0]      op;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic            ld;
        logic            st;
        logic            amo;
        logic            lr;
        logic            no_regs;
        op      = w[6:0];
        f3      = w[14:12];
        f7      = w[31:25];
        ld      = (op == rv32_pkg::OP_LOAD) || (op == rv32_pkg::OP_LOAD_FP);
        st      = (op == rv32_pkg::OP_STORE) || (op == rv32_pkg::OP_STORE_FP);
        amo     = (op == rv32_pkg::OP_AMO);
        lr      = amo && (f3 == 3'b010) && (w[31:27] == 5'b00010) && (w[24:20] == 5'd0);
        no_regs = (w[19:15] == 5'd0) && (w[11:7] == 5'd0);
        c = '0;
        c[rv32_pkg::CTRL_WRITES_RF] = (w[11:7] != 5'd0) && (op inside {rv32_pkg::OP_LUI,
            rv32_pkg::OP_AUIPC, rv32_pkg::OP_JAL, rv32_pkg::OP_JALR, rv32_pkg::OP_LOAD,
            rv32_pkg::OP_IMM, rv32_pkg::OP_OP, rv32_pkg::OP_AMO});
        c[rv32_pkg::CTRL_IS_MEM]        = ld || st || amo;
        c[rv32_pkg::CTRL_IS_BYTE]       = (ld || st || amo) && (f3[1:0] == 2'b00);
        c[rv32_pkg::CTRL_IS_HEX]        = (ld || st || amo) && (f3[1:0] == 2'b01);
        c[rv32_pkg::CTRL_IS_STORE]      = st || (amo && f7 == rv32_pkg::FUNCT7_SWAP_RL);
        c[rv32_pkg::CTRL_IS_LOAD]       = ld || (amo && f7 != rv32_pkg::FUNCT7_SWAP_RL);
        c[rv32_pkg::CTRL_LOAD_UNSIGNED] = c[rv32_pkg::CTRL_IS_LOAD] && f3[2];
        c[rv32_pkg::CTRL_IS_BRANCH]     = (op == rv32_pkg::OP_BRANCH);
        c[rv32_pkg::CTRL_IS_JUMP]       = op inside {rv32_pkg::OP_JAL, rv32_pkg::OP_JALR};
        c[rv32_pkg::CTRL_READS_RF1]     = ld || st || amo || (op inside {rv32_pkg::OP_JALR,
            rv32_pkg::OP_BRANCH, rv32_pkg::OP_OP, rv32_pkg::OP_IMM});
        // FSW takes its data from a float register
        c[rv32_pkg::CTRL_READS_RF2]     = (op inside {rv32_pkg::OP_BRANCH, rv32_pkg::OP_STORE,
            rv32_pkg::OP_OP}) || (amo && (f7 inside {rv32_pkg::FUNCT7_SWAP_AQ,
            rv32_pkg::FUNCT7_SWAP_RL}));
        c[rv32_pkg::CTRL_IS_AUIPC]      = (op == rv32_pkg::OP_AUIPC);
        c[rv32_pkg::CTRL_IS_MD]         = (op == rv32_pkg::OP_OP)
            && (f7 == rv32_pkg::FUNCT7_MULDIV);
        c[rv32_pkg::CTRL_IS_LR]         = lr;
        c[rv32_pkg::CTRL_LR_ACQ]        = lr && w[26];
        c[rv32_pkg::CTRL_IS_FENCE]      = (op == rv32_pkg::OP_MISC_MEM) && no_regs
            && (f3 == rv32_pkg::FUNCT3_FENCE) && (w[31:28] == 4'd0);
        c[rv32_pkg::CTRL_IS_FENCE_I]    = (op == rv32_pkg::OP_MISC_MEM) && no_regs
            && (f3 == rv32_pkg::FUNCT3_FENCE_I) && (w[31:20] == 12'd0);
        c[rv32_pkg::CTRL_SWAP_AQ] = amo && (f3 == 3'b010) && (f7 == rv32_pkg::FUNCT7_SWAP_AQ);
        c[rv32_pkg::CTRL_SWAP_RL] = amo && (f3 == 3'b010) && (f7 == rv32_pkg::FUNCT7_SWAP_RL);
        return c;
    endfunction

    // Immediate by format with sign extension through signed casts
    function automatic rv32_pkg::word_t model_imm(input rv32_pkg::instr_t w);
        case (w[6:0])
            rv32_pkg::OP_LOAD, rv32_pkg::OP_LOAD_FP, rv32_pkg::OP_IMM,
            rv32_pkg::OP_JALR, rv32_pkg::OP_AMO:
                return 32'($signed(w[31:20]));
            rv32_pkg::OP_STORE, rv32_pkg::OP_STORE_FP:
                return 32'($signed({w[31:25], w[11:7]}));
            rv32_pkg::OP_BRANCH:
                return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            rv32_pkg::OP_LUI, rv32_pkg::OP_AUIPC:
                return {w[31:12], 12'h000};
            rv32_pkg::OP_JAL:
                return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default:
                return '0;
        endcase
    endfunction

    function automatic rv32_pkg::word_t model_read(input rv32_pkg::reg_addr_t a,
                                                   input logic en);
        // shadow[0] is never written
        return en ? shadow[a] : '0;
    endfunction

    function automatic rv32_pkg::instr_t random_instr();
        rv32_pkg::word_t sel;
        rv32_pkg::word_t body;
        sel  = $random(seed);
        body = $random(seed);
        return {body[31:7], OPCODE_POOL[sel[3:0]]};
    endfunction

    task automatic write_reg(input rv32_pkg::reg_addr_t a, input rv32_pkg::word_t d);
        @(posedge clk_i);
        #1;
        wb_en_i   = 1'b1;
        wb_addr_i = a;
        wb_data_i = d;
        @(posedge clk_i);
        #1;
        wb_en_i = 1'b0;
        if (a != 5'd0) begin
            shadow[a] = d;
        end
    endtask

    task automatic send_instr(input rv32_pkg::instr_t w);
        bundle_t e;
        int      n;
        e.ctrl    = model_ctrl(w);
        e.rd      = w[11:7];
        e.imm     = model_imm(w);
        e.rs1_val = model_read(w[19:15], e.ctrl[rv32_pkg::CTRL_READS_RF1]);
        e.rs2_val = model_read(w[24:20], e.ctrl[rv32_pkg::CTRL_READS_RF2]);
        exp_q.push_back(e);
        @(posedge clk_i);
        #1;
        in_instr_i     = w;
        in_req_i       = 1'b1;
        first_req_seen = 1'b1;
        n = 0;
        while (!in_ack_o) begin
            if (n == WAIT_CYCLES) give_up("timeout waiting for in_ack_o to rise");
            @(posedge clk_i);
            #1;
            n++;
        end
        in_req_i = 1'b0;
        n = 0;
        while (in_ack_o) begin
            if (n == WAIT_CYCLES) give_up("timeout waiting for in_ack_o to fall");
            @(posedge clk_i);
            #1;
            n++;
        end
    endtask

    task automatic accept_result();
        bundle_t e;
        int      n;
        int      delay;
        n = 0;
        while (!out_req_o) begin
            if (n == WAIT_CYCLES) give_up("timeout waiting for out_req_o to rise");
            @(posedge clk_i);
            #1;
            n++;
        end
        if (exp_q.size() == 0) give_up("out_req_o rose with no instruction outstanding");
        e = exp_q.pop_front();
        check_field("out_ctrl_o", 32'(e.ctrl), 32'(out_ctrl_o));
        check_field("out_rd_o", 32'(e.rd), 32'(out_rd_o));
        check_field("out_imm_o", e.imm, out_imm_o);
        check_field("out_rs1_val_o", e.rs1_val, out_rs1_val_o);
        check_field("out_rs2_val_o", e.rs2_val, out_rs2_val_o);
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(posedge clk_i);
            #1;
        end
        out_ack_i = 1'b1;
        n = 0;
        while (out_req_o) begin
            if (n == WAIT_CYCLES) give_up("timeout waiting for out_req_o to fall");
            @(posedge clk_i);
            #1;
            n++;
        end
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(posedge clk_i);
            #1;
        end
        out_ack_i = 1'b0;
    endtask

    // Producer and consumer run side by side to keep several words in flight
    task automatic run_batch();
        int count;
        count = stim_q.size();
        fork
            begin
                while (stim_q.size() > 0) begin
                    send_instr(stim_q.pop_front());
                end
            end
            begin
                repeat (count) accept_result();
            end
        join
        if (exp_q.size() != 0) give_up("instructions missing at the output after a batch");
    endtask

    initial begin
        int i;
        seed           = 55;
        reset_i        = 1'b1;
        in_req_i       = 1'b0;
        in_instr_i     = '0;
        out_ack_i      = 1'b0;
        wb_en_i        = 1'b0;
        wb_addr_i      = '0;
        wb_data_i      = '0;
        first_req_seen = 1'b0;
        for (i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // Every register gets a value and the write to x0 is dropped
        for (i = 0; i < 32; i++) begin
            write_reg(5'(i), $random(seed));
        end

        stim_q.push_back({20'h12345, 5'd5, rv32_pkg::OP_LUI});
        stim_q.push_back({20'hFFFFF, 5'd7, rv32_pkg::OP_AUIPC});
        stim_q.push_back({1'b1, 10'h3F0, 1'b1, 8'hFF, 5'd1, rv32_pkg::OP_JAL});
        stim_q.push_back({12'hFFC, 5'd2, 3'b000, 5'd1, rv32_pkg::OP_JALR});
        stim_q.push_back({7'h7F, 5'd4, 5'd3, 3'b001, 5'h1D, rv32_pkg::OP_BRANCH});
        stim_q.push_back({12'hFFF, 5'd3, 3'b000, 5'd6, rv32_pkg::OP_LOAD});
        stim_q.push_back({12'h7FE, 5'd9, 3'b101, 5'd8, rv32_pkg::OP_LOAD});
        stim_q.push_back({7'h7F, 5'd10, 5'd11, 3'b001, 5'h18, rv32_pkg::OP_STORE});
        stim_q.push_back({12'd16, 5'd12, 3'b010, 5'd1, rv32_pkg::OP_LOAD_FP});
        stim_q.push_back({7'd0, 5'd2, 5'd13, 3'b010, 5'd20, rv32_pkg::OP_STORE_FP});
        stim_q.push_back({7'b0100000, 5'd16, 5'd15, 3'b000, 5'd14, rv32_pkg::OP_OP});
        stim_q.push_back({12'h800, 5'd17, 3'b000, 5'd18, rv32_pkg::OP_IMM});
        stim_q.push_back({rv32_pkg::FUNCT7_MULDIV, 5'd21, 5'd20, 3'b000, 5'd19, rv32_pkg::OP_OP});
        // LR.W plain and with acquire
        stim_q.push_back({5'b00010, 2'b00, 5'd0, 5'd23, 3'b010, 5'd22, rv32_pkg::OP_AMO});
        stim_q.push_back({5'b00010, 2'b10, 5'd0, 5'd23, 3'b010, 5'd22, rv32_pkg::OP_AMO});
        stim_q.push_back({rv32_pkg::FUNCT7_SWAP_AQ, 5'd24, 5'd25, 3'b010, 5'd26, rv32_pkg::OP_AMO});
        stim_q.push_back({rv32_pkg::FUNCT7_SWAP_RL, 5'd24, 5'd25, 3'b010, 5'd26, rv32_pkg::OP_AMO});
        stim_q.push_back({4'd0, 4'hF, 4'hF, 5'd0, 3'b000, 5'd0, rv32_pkg::OP_MISC_MEM});
        stim_q.push_back({12'd0, 5'd0, 3'b001, 5'd0, rv32_pkg::OP_MISC_MEM});
        stim_q.push_back({7'd0, 5'd2, 5'd1, 3'b000, 5'd0, rv32_pkg::OP_OP});
        stim_q.push_back({7'd0, 5'd0, 5'd0, 3'b000, 5'd3, rv32_pkg::OP_OP});
        run_batch();

        // New values while the pipeline is empty
        repeat (8) begin
            write_reg(5'($random(seed)), $random(seed));
        end

        repeat (200) begin
            stim_q.push_back(random_instr());
        end
        run_batch();

        repeat (4) begin
            @(posedge clk_i);
            #1;
            if (in_ack_o || out_req_o) begin
                give_up("handshake still active after the last instruction");
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/rv32_pkg.sv
hw/instr_rx.sv
hw/cl_decode.sv
hw/decode_stage.sv
hw/operand_stage.sv
hw/result_tx.sv
hw/decode_top.sv
testbench/tb_decode_top.sv
